//--- verilog.f
common/matmul_cfg_pkg.sv
common/matmul_types_pkg.sv
src/step_counter.sv
src/matmul_ctrl.sv
src/operand_mem.sv
compute/outer_product_array.sv
src/result_mem.sv
src/matmul_top.sv
tests/tb_matmul.sv

//--- Makefile
# Verilator build and run of the matrix multiplier testbench

SRCS := $(shell cat verilog.f)

.PHONY: run clean

run: obj_dir/Vtb_matmul
	./obj_dir/Vtb_matmul

# Rebuilt only when a source or the file list changes
obj_dir/Vtb_matmul: verilog.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module tb_matmul -f verilog.f

clean:
	rm -rf obj_dir

//--- tests/tb_matmul.sv
`timescale 1ns/1ns
`default_nettype none

module tb_matmul
  import matmul_cfg_pkg::*;
  import matmul_types_pkg::*;
;

  localparam int MAT_SIZE   = DEFAULT_MAT_SIZE;
  localparam int IDX_W      = $clog2(MAT_SIZE);
  localparam int CLK_PERIOD = 40;
  // Load, one run and a full readback, with margin
  localparam int TEST_CYCLES  = 8 * MAT_SIZE + 24;
  localparam int WATCHDOG_NS  = (6 * TEST_CYCLES + 8) * CLK_PERIOD;

  logic                 clk = 1'b0;
  logic                 reset_0;
  host_op_e             host_op;
  logic [IDX_W-1:0]     host_addr;
  elem_t [MAT_SIZE-1:0] host_wdata;
  logic                 start;
  elem_t [MAT_SIZE-1:0] host_rdata;
  logic                 host_rdata_valid;
  logic                 busy;
  logic                 done;

  // a_mat[i][k], b_mat[k][j], c_exp[i][j]
  elem_t a_mat [MAT_SIZE][MAT_SIZE];
  elem_t b_mat [MAT_SIZE][MAT_SIZE];
  elem_t c_exp [MAT_SIZE][MAT_SIZE];

  always #(CLK_PERIOD / 2) clk = ~clk;

  matmul_top #(.MAT_SIZE(MAT_SIZE)) dut_i (
    .clk(clk), .reset_0(reset_0), .host_op(host_op), .host_addr(host_addr),
    .host_wdata(host_wdata), .start(start), .host_rdata(host_rdata),
    .host_rdata_valid(host_rdata_valid), .busy(busy), .done(done)
  );

  //////////////////////////////
  // Failure and compare tasks
  //////////////////////////////

  task automatic abort_run();
    $display("TESTBENCH FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_elem(input string name, input elem_t exp, input elem_t act);
    if (act !== exp) begin
      $display("FAILED time=%0t signal=%s expected=0x%h actual=0x%h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED time=%0t signal=%s expected=%b actual=%b", $time, name, exp, act);
      abort_run();
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the DUT stopped responding", WATCHDOG_NS);
    abort_run();
  end

  //////////////////////////////
  // Host side tasks
  //////////////////////////////

  task automatic write_a_col(input int idx, input elem_t [MAT_SIZE-1:0] col);
    @(posedge clk);
    host_op    <= OP_WRITE_A;
    host_addr  <= IDX_W'(idx);
    host_wdata <= col;
  endtask

  task automatic write_b_row(input int idx, input elem_t [MAT_SIZE-1:0] row);
    @(posedge clk);
    host_op    <= OP_WRITE_B;
    host_addr  <= IDX_W'(idx);
    host_wdata <= row;
  endtask

  task automatic load_matrices();
    elem_t [MAT_SIZE-1:0] vec;
    for (int k = 0; k < MAT_SIZE; k++) begin
      for (int i = 0; i < MAT_SIZE; i++) vec[i] = a_mat[i][k];
      write_a_col(k, vec);
    end
    for (int k = 0; k < MAT_SIZE; k++) begin
      for (int j = 0; j < MAT_SIZE; j++) vec[j] = b_mat[k][j];
      write_b_row(k, vec);
    end
    @(posedge clk);
    host_op <= OP_NONE;
  endtask

  // Pulses start, then counts edges up to done
  task automatic run_matmul(input bit poke_a);
    int edges;
    bit seen;
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    check_flag("busy", 1'b0, busy);
    edges = 0;
    seen = 1'b0;
    while (!seen && edges < 4 * MAT_SIZE + 8) begin
      @(posedge clk);
      edges++;
      check_flag("busy", 1'b1, busy);
      seen = done;
      // Host write while busy must be dropped
      if (poke_a && edges == 1) begin
        host_op    <= OP_WRITE_A;
        host_addr  <= '0;
        host_wdata <= {MAT_SIZE{16'hDEAD}};
      end
      if (edges == 2 * MAT_SIZE) host_op <= OP_NONE;
    end
    if (!seen) begin
      $display("done never came within %0d edges after start", edges);
      abort_run();
    end else if (edges != 2 * MAT_SIZE + 2) begin
      $display("done came %0d edges after start instead of %0d", edges, 2 * MAT_SIZE + 2);
      abort_run();
    end
    @(posedge clk);
    check_flag("done", 1'b0, done);
    check_flag("busy", 1'b0, busy);
  endtask

  task automatic read_c_row(input int row);
    int waited;
    @(posedge clk);
    host_op   <= OP_READ_C;
    host_addr <= IDX_W'(row);
    @(posedge clk);
    host_op <= OP_NONE;
    @(posedge clk);
    waited = 1;
    while (!host_rdata_valid && waited < 4) begin
      @(posedge clk);
      waited++;
    end
    if (!host_rdata_valid || waited != 2) begin
      $display("host_rdata_valid for row %0d missing or late, waited %0d edges", row, waited);
      abort_run();
    end
    for (int j = 0; j < MAT_SIZE; j++) begin
      check_elem($sformatf("host_rdata[%0d][%0d]", row, j), c_exp[row][j], host_rdata[j]);
    end
    @(posedge clk);
    check_flag("host_rdata_valid", 1'b0, host_rdata_valid);
  endtask

  task automatic read_all_rows();
    for (int r = 0; r < MAT_SIZE; r++) read_c_row(r);
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic void fill_random();
    for (int i = 0; i < MAT_SIZE; i++) begin
      for (int j = 0; j < MAT_SIZE; j++) begin
        a_mat[i][j] = elem_t'($urandom());
        b_mat[i][j] = elem_t'($urandom());
      end
    end
  endfunction

  // Sum of products, wraps at 16 bits
  function automatic void compute_model();
    elem_t sum;
    for (int i = 0; i < MAT_SIZE; i++) begin
      for (int j = 0; j < MAT_SIZE; j++) begin
        sum = '0;
        for (int k = 0; k < MAT_SIZE; k++) sum = sum + a_mat[i][k] * b_mat[k][j];
        c_exp[i][j] = sum;
      end
    end
  endfunction

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic test_reset_state();
    @(posedge clk);
    check_flag("busy", 1'b0, busy);
    check_flag("done", 1'b0, done);
    check_flag("host_rdata_valid", 1'b0, host_rdata_valid);
  endtask

  task automatic test_identity();
    fill_random();
    for (int i = 0; i < MAT_SIZE; i++) begin
      for (int j = 0; j < MAT_SIZE; j++) begin
        a_mat[i][j] = (i == j) ? elem_t'(1) : elem_t'(0);
        c_exp[i][j] = b_mat[i][j];
      end
    end
    load_matrices();
    run_matmul(1'b0);
    read_all_rows();
  endtask

  task automatic test_random_product();
    fill_random();
    compute_model();
    load_matrices();
    run_matmul(1'b0);
    read_all_rows();
  endtask

  // Back to back runs on loaded operands
  task automatic test_done_timing();
    run_matmul(1'b0);
    run_matmul(1'b0);
  endtask

  task automatic test_write_while_busy();
    fill_random();
    compute_model();
    load_matrices();
    run_matmul(1'b0);
    read_all_rows();
    run_matmul(1'b1);
    read_all_rows();
  endtask

  // 0xFFFF squared is 1 mod 2^16
  task automatic test_wraparound();
    for (int i = 0; i < MAT_SIZE; i++) begin
      for (int j = 0; j < MAT_SIZE; j++) begin
        a_mat[i][j] = 16'hFFFF;
        b_mat[i][j] = 16'hFFFF;
        c_exp[i][j] = elem_t'(MAT_SIZE);
      end
    end
    load_matrices();
    run_matmul(1'b0);
    read_all_rows();
  endtask

  initial begin
    void'($urandom(15));
    reset_0    <= 1'b1;
    host_op    <= OP_NONE;
    host_addr  <= '0;
    host_wdata <= '0;
    start      <= 1'b0;
    repeat (8) @(posedge clk);
    reset_0 <= 1'b0;

    test_reset_state();
    test_identity();
    test_random_product();
    test_done_timing();
    test_write_while_busy();
    test_wraparound();

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- src/matmul_top.sv
`timescale 1ns/1ns
`default_nettype none

module matmul_top
  import matmul_cfg_pkg::*;
  import matmul_types_pkg::*;
#(
  parameter int MAT_SIZE = DEFAULT_MAT_SIZE
) (
  input  logic                              clk,
  input  logic                              reset_0,
  input  host_op_e                          host_op,
  input  logic [$clog2(MAT_SIZE)-1:0]       host_addr,
  input  elem_t [MAT_SIZE-1:0]              host_wdata,
  input  logic                              start,
  output elem_t [MAT_SIZE-1:0]              host_rdata,
  output logic                              host_rdata_valid,
  output logic                              busy,
  output logic                              done
);

  localparam int IDX_W = $clog2(MAT_SIZE);

  logic wr_a;
  logic wr_b;
  logic rd_c;
  logic cnt_clear;
  logic cnt_step;
  logic acc_clear;
  logic acc_en;
  logic store_en;
  logic last;
  logic [IDX_W-1:0] count;

  elem_t [MAT_SIZE-1:0] a_col;
  elem_t [MAT_SIZE-1:0] b_row;
  elem_t [MAT_SIZE-1:0] c_row;

  //////////////////////////////
  // Control
  //////////////////////////////

  matmul_ctrl #(.MAT_SIZE(MAT_SIZE)) ctrl_i (
    .clk(clk), .reset_0(reset_0), .host_op(host_op), .start(start), .last(last),
    .wr_a(wr_a), .wr_b(wr_b), .rd_c(rd_c), .cnt_clear(cnt_clear), .cnt_step(cnt_step),
    .acc_clear(acc_clear), .acc_en(acc_en), .store_en(store_en), .busy(busy), .done(done)
  );

  // Shared k index in accumulate, row index in store
  step_counter #(.MAT_SIZE(MAT_SIZE)) counter_i (
    .clk(clk), .reset_0(reset_0), .clear(cnt_clear), .step(cnt_step),
    .count(count), .last(last)
  );

  //////////////////////////////
  // Operand memories
  //////////////////////////////

  // A holds one column per address, B one row per address
  operand_mem #(.MAT_SIZE(MAT_SIZE)) a_mem_i (
    .clk(clk), .reset_0(reset_0), .host_wr(wr_a), .host_addr(host_addr),
    .eng_addr(count), .wdata(host_wdata), .busy(busy), .rdata(a_col)
  );

  operand_mem #(.MAT_SIZE(MAT_SIZE)) b_mem_i (
    .clk(clk), .reset_0(reset_0), .host_wr(wr_b), .host_addr(host_addr),
    .eng_addr(count), .wdata(host_wdata), .busy(busy), .rdata(b_row)
  );

  //////////////////////////////
  // Compute and result
  //////////////////////////////

  outer_product_array #(.MAT_SIZE(MAT_SIZE)) array_i (
    .clk(clk), .reset_0(reset_0), .acc_clear(acc_clear), .acc_en(acc_en),
    .a_col(a_col), .b_row(b_row), .row_sel(count), .c_row(c_row)
  );

  result_mem #(.MAT_SIZE(MAT_SIZE)) c_mem_i (
    .clk(clk), .reset_0(reset_0), .store_en(store_en), .store_addr(count),
    .store_data(c_row), .rd_c(rd_c), .host_addr(host_addr),
    .host_rdata(host_rdata), .host_rdata_valid(host_rdata_valid)
  );

endmodule

`default_nettype wire

//--- src/result_mem.sv
`timescale 1ns/1ns
`default_nettype none

module result_mem
  import matmul_cfg_pkg::*;
#(
  parameter int MAT_SIZE = DEFAULT_MAT_SIZE
) (
  input  logic                        clk,
  input  logic                        reset_0,
  input  logic                        store_en,
  input  logic [$clog2(MAT_SIZE)-1:0] store_addr,
  input  elem_t [MAT_SIZE-1:0]        store_data,
  input  logic                        rd_c,
  input  logic [$clog2(MAT_SIZE)-1:0] host_addr,
  output elem_t [MAT_SIZE-1:0]        host_rdata,
  output logic                        host_rdata_valid
);

  localparam int IDX_W = $clog2(MAT_SIZE);

  elem_t [MAT_SIZE-1:0] mem [MAT_SIZE];
  logic  [IDX_W-1:0]    rd_addr_q;
  logic                 rd_q;

  // Engine side, one row per store cycle
  always_ff @(posedge clk) begin
    if (store_en) begin
      mem[store_addr] <= store_data;
    end
    // Data holds until the next host read
    if (rd_q) begin
      host_rdata <= mem[rd_addr_q];
    end
  end

  // Host read request stage, valid follows the data register
  always_ff @(posedge clk) begin
    if (reset_0) begin
      rd_addr_q        <= '0;
      rd_q             <= 1'b0;
      host_rdata_valid <= 1'b0;
    end else begin
      if (rd_c) rd_addr_q <= host_addr;
      rd_q             <= rd_c;
      host_rdata_valid <= rd_q;
    end
  end

endmodule

`default_nettype wire

//--- compute/outer_product_array.sv
`timescale 1ns/1ns
`default_nettype none

module outer_product_array
  import matmul_cfg_pkg::*;
#(
  parameter int MAT_SIZE = DEFAULT_MAT_SIZE
) (
  input  logic                        clk,
  input  logic                        reset_0,
  input  logic                        acc_clear,
  input  logic                        acc_en,
  input  elem_t [MAT_SIZE-1:0]        a_col,
  input  elem_t [MAT_SIZE-1:0]        b_row,
  input  logic [$clog2(MAT_SIZE)-1:0] row_sel,
  output elem_t [MAT_SIZE-1:0]        c_row
);

  //////////////////////////////
  // Accumulator grid
  //////////////////////////////

  // acc[i][j] collects a_col[i] * b_row[j] over k
  elem_t [MAT_SIZE-1:0] acc [MAT_SIZE];
  elem_t [MAT_SIZE-1:0] prod [MAT_SIZE];

  // Products truncated to element width
  always_comb begin
    for (int i = 0; i < MAT_SIZE; i++) begin
      for (int j = 0; j < MAT_SIZE; j++) begin
        prod[i][j] = elem_t'(a_col[i] * b_row[j]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset_0 || acc_clear) begin
      for (int i = 0; i < MAT_SIZE; i++) begin
        acc[i] <= '0;
      end
    end else if (acc_en) begin
      for (int i = 0; i < MAT_SIZE; i++) begin
        for (int j = 0; j < MAT_SIZE; j++) begin
          acc[i][j] <= acc[i][j] + prod[i][j];
        end
      end
    end
  end

  //////////////////////////////
  // Row readout
  //////////////////////////////

  // One C row per store cycle
  assign c_row = acc[row_sel];

endmodule

`default_nettype wire

//--- src/operand_mem.sv
`timescale 1ns/1ns
`default_nettype none

module operand_mem
  import matmul_cfg_pkg::*;
#(
  parameter int MAT_SIZE = DEFAULT_MAT_SIZE
) (
  input  logic                        clk,
  input  logic                        reset_0,
  input  logic                        host_wr,
  input  logic [$clog2(MAT_SIZE)-1:0] host_addr,
  input  logic [$clog2(MAT_SIZE)-1:0] eng_addr,
  input  elem_t [MAT_SIZE-1:0]        wdata,
  input  logic                        busy,
  output elem_t [MAT_SIZE-1:0]        rdata
);

  localparam int IDX_W = $clog2(MAT_SIZE);

  elem_t [MAT_SIZE-1:0] mem [MAT_SIZE];
  elem_t [MAT_SIZE-1:0] wdata_q;
  logic  [IDX_W-1:0]    addr_q;
  logic                 wr_q;

  // Registered address mux, host while idle and engine while busy
  always_ff @(posedge clk) begin
    if (reset_0) begin
      addr_q <= '0;
      wr_q   <= 1'b0;
    end else begin
      addr_q <= busy ? eng_addr : host_addr;
      wr_q   <= host_wr;
    end
  end

  always_ff @(posedge clk) begin
    wdata_q <= wdata;
    if (wr_q) begin
      mem[addr_q] <= wdata_q;
    end
  end

  // Read port follows the registered address
  assign rdata = mem[addr_q];

endmodule

`default_nettype wire

//--- src/matmul_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module matmul_ctrl
  import matmul_cfg_pkg::*;
  import matmul_types_pkg::*;
#(
  parameter int MAT_SIZE = DEFAULT_MAT_SIZE
) (
  input  logic     clk,
  input  logic     reset_0,
  input  host_op_e host_op,
  input  logic     start,
  input  logic     last,
  output logic     wr_a,
  output logic     wr_b,
  output logic     rd_c,
  output logic     cnt_clear,
  output logic     cnt_step,
  output logic     acc_clear,
  output logic     acc_en,
  output logic     store_en,
  output logic     busy,
  output logic     done
);

  ctrl_state_e state;
  ctrl_state_e state_nxt;
  logic        idle;
  logic        acc_en_q;

  assign idle = (state == ST_IDLE);

  always_ff @(posedge clk) begin
    if (reset_0) begin
      state    <= ST_IDLE;
      acc_en_q <= 1'b0;
    end else begin
      state    <= state_nxt;
      // Operand words arrive one cycle after count
      acc_en_q <= (state == ST_ACCUM);
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE:  if (start) state_nxt = ST_ACCUM;
      ST_ACCUM: if (last) state_nxt = ST_FLUSH;
      // Last outer product lands during this cycle
      ST_FLUSH: state_nxt = ST_STORE;
      ST_STORE: if (last) state_nxt = ST_DONE;
      ST_DONE:  state_nxt = ST_IDLE;
      default:  state_nxt = ST_IDLE;
    endcase
  end

  // Host strobes only while idle
  assign wr_a = idle && (host_op == OP_WRITE_A);
  assign wr_b = idle && (host_op == OP_WRITE_B);
  assign rd_c = idle && (host_op == OP_READ_C);

  assign cnt_clear = idle && start;
  assign acc_clear = idle && start;
  assign cnt_step  = (state == ST_ACCUM) || (state == ST_STORE);
  assign acc_en    = acc_en_q;
  assign store_en  = (state == ST_STORE);
  assign busy      = !idle;
  assign done      = (state == ST_DONE);

  // done trails the sampled start by the whole multiply sequence
  a_done_timing: assert property (@(posedge clk) disable iff (reset_0)
    done |-> $past(idle && start, 2 * MAT_SIZE + 2));

  // Flush cycle keeps accumulation and storing apart
  a_store_after_acc: assert property (@(posedge clk) disable iff (reset_0)
    store_en |-> !acc_en);

endmodule

`default_nettype wire

//--- src/step_counter.sv
`timescale 1ns/1ns
`default_nettype none

module step_counter
  import matmul_cfg_pkg::*;
#(
  parameter int MAT_SIZE = DEFAULT_MAT_SIZE
) (
  input  logic                        clk,
  input  logic                        reset_0,
  input  logic                        clear,
  input  logic                        step,
  output logic [$clog2(MAT_SIZE)-1:0] count,
  output logic                        last
);

  localparam int IDX_W = $clog2(MAT_SIZE);
  localparam logic [IDX_W-1:0] MAX_IDX = IDX_W'(MAT_SIZE - 1);

  assign last = (count == MAX_IDX);

  always_ff @(posedge clk) begin
    if (reset_0 || clear) begin
      count <= '0;
    end else if (step) begin
      // Wrap so the next phase starts at zero
      count <= last ? '0 : count + 1'b1;
    end
  end

  // Clear only comes between phases
  a_clear_not_step: assert property (@(posedge clk) disable iff (reset_0)
    !(clear && step));

endmodule

`default_nettype wire

//--- common/matmul_types_pkg.sv
`default_nettype none

package matmul_types_pkg;

  // Host request, one per cycle while the engine is idle
  typedef enum logic [1:0] {
    OP_NONE    = 2'd0,
    OP_WRITE_A = 2'd1,
    OP_WRITE_B = 2'd2,
    OP_READ_C  = 2'd3
  } host_op_e;

  // Multiply sequence
  typedef enum logic [2:0] {
    ST_IDLE  = 3'd0,
    ST_ACCUM = 3'd1,
    ST_FLUSH = 3'd2,
    ST_STORE = 3'd3,
    ST_DONE  = 3'd4
  } ctrl_state_e;

endpackage

`default_nettype wire

//--- common/matmul_cfg_pkg.sv
`default_nettype none

package matmul_cfg_pkg;

  //////////////////////////////
  // Element format
  //////////////////////////////

  // Unsigned elements, all arithmetic wraps at this width
  localparam int ELEM_WIDTH = 16;

  typedef logic [ELEM_WIDTH-1:0] elem_t;

  //////////////////////////////
  // Matrix geometry
  //////////////////////////////

  // Side of the square product when the top level is not overridden
  localparam int DEFAULT_MAT_SIZE = 4;

endpackage

`default_nettype wire
